// ==== cpu_pkg.sv ====
// cpu_pkg
// shared types, state and opcode encodings for the multi-cycle RV32I core
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;    // data or address word
	typedef logic [4:0]  reg_adr_t; // x0..x31

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PC,
		ST_IMR,
		ST_IDRFR,
		ST_EX,
		ST_DMRW,
		ST_HALT
	} cpu_state_e;

	// RV32I major opcodes, only the supported subset
	typedef enum logic [6:0] {
		OP_ALU    = 7'b0110011,
		OP_ALUI   = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	localparam word_t INST_STEP  = 32'd4;          // sequential pc step
	localparam word_t INST_ECALL = 32'h0000_0073;  // full ecall encoding

	localparam logic [2:0] F3_ADD  = 3'b000;  // also sub, addi
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010;  // lw / sw
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_SUB  = 7'h20;

endpackage

`default_nettype wire

// ==== cpu_state_machine.sv ====
// cpu state machine
// sequences pc, imr, idrfr, ex and dmrw for one instruction at a time,
// starts on cpu_start, parks in idle on quit and in halt on ecall or
// an illegal opcode
`timescale 1ns/1ps
`default_nettype none

module cpu_state_machine import cpu_pkg::*; (
	input  wire  clk,
	input  wire  i_rst_n,
	input  wire  i_cpu_start,
	input  wire  i_quit_cmd,
	input  wire  i_imr_run,
	input  wire  i_dmrw_run,
	input  wire  i_halt_req,
	output logic o_stat_pc,
	output logic o_stat_imr,
	output logic o_stat_idrfr,
	output logic o_stat_ex,
	output logic o_stat_dmrw,
	output logic o_halted
);

	cpu_state_e state;
	cpu_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE, ST_HALT: begin
				if (i_cpu_start)
					state_nxt = ST_PC;
			end
			ST_PC:    state_nxt = ST_IMR;
			ST_IMR: begin
				if (!i_imr_run)
					state_nxt = ST_IDRFR;  // fetch returned
			end
			ST_IDRFR: state_nxt = ST_EX;
			ST_EX:    state_nxt = i_halt_req ? ST_HALT : ST_DMRW;
			ST_DMRW: begin
				if (!i_dmrw_run)
					state_nxt = i_quit_cmd ? ST_IDLE : ST_PC;  // quit only seen here
			end
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	assign o_stat_pc    = (state == ST_PC);
	assign o_stat_imr   = (state == ST_IMR);
	assign o_stat_idrfr = (state == ST_IDRFR);
	assign o_stat_ex    = (state == ST_EX);
	assign o_stat_dmrw  = (state == ST_DMRW);
	assign o_halted     = (state == ST_HALT);

	// busy levels only come from the stage that owns them
	ap_run_in_stage: assert property (@(posedge clk) disable iff (!i_rst_n)
		(!i_imr_run || o_stat_imr) && (!i_dmrw_run || o_stat_dmrw));

	// a halting instruction never gets as far as dmrw
	ap_halt_before_dmrw: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_stat_dmrw |-> !i_halt_req);

endmodule

`default_nettype wire

// ==== pc_stage.sv ====
// program counter
// loads the start address, then steps by 4 or takes the jump target
// at the end of ex
`timescale 1ns/1ps
`default_nettype none

module pc_stage import cpu_pkg::*; (
	input  wire        clk,
	input  wire        i_rst_n,
	input  wire        i_cpu_start,
	input  wire word_t i_cpu_start_adr,
	input  wire        i_stat_ex,
	input  wire        i_jmp_cond,
	input  wire word_t i_jmp_adr,
	output word_t      o_pc
);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_pc <= '0;
		else if (i_cpu_start)
			o_pc <= i_cpu_start_adr;
		else if (i_stat_ex)
			o_pc <= i_jmp_cond ? i_jmp_adr : o_pc + INST_STEP;  // branch, jal or halt self
	end

	ap_pc_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== inst_mem_read.sv ====
// instruction fetch
// requests the word at pc for the whole imr stage and latches it
// when read_valid returns
`timescale 1ns/1ps
`default_nettype none

module inst_mem_read import cpu_pkg::*; (
	input  wire        clk,
	input  wire        i_rst_n,
	input  wire        i_stat_imr,
	input  wire word_t i_pc,
	input  wire        i_read_valid,
	input  wire word_t i_read_data,
	output logic       o_i_read_req,
	output word_t      o_i_read_adr,
	output word_t      o_inst,
	output logic       o_imr_run
);

	assign o_i_read_req = i_stat_imr;                  // held until valid
	assign o_i_read_adr = i_pc;
	assign o_imr_run    = i_stat_imr & ~i_read_valid;  // done in the valid cycle

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_inst <= '0;
		else if (i_stat_imr && i_read_valid)
			o_inst <= i_read_data;  // stays until the next fetch
	end

	// the state machine must leave imr right after the data arrives
	ap_req_release: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_i_read_req && i_read_valid) |=> !o_i_read_req);

	ap_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_i_read_req && !i_read_valid) |=> (o_i_read_req && $stable(o_i_read_adr)));

endmodule

`default_nettype wire

// ==== decoder.sv ====
// instruction decoder
// splits the fetched word into command flags, alu op, register
// numbers and the sign-extended immediate, flags anything outside
// the supported subset as illegal
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
	input  wire word_t i_inst,
	output alu_op_e    o_alu_op,
	output logic       o_use_imm,
	output logic       o_cmd_ld,
	output logic       o_cmd_st,
	output logic       o_cmd_br,
	output logic       o_br_ne,
	output logic       o_cmd_jal,
	output logic       o_cmd_ecall,
	output logic       o_illegal_ops,
	output logic       o_wbk_rd_reg,
	output reg_adr_t   o_rd_adr,
	output reg_adr_t   o_rs1_adr,
	output reg_adr_t   o_rs2_adr,
	output word_t      o_imm
);

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;

	assign opcode = opcode_e'(i_inst[6:0]);
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	assign o_rd_adr  = i_inst[11:7];
	assign o_rs1_adr = i_inst[19:15];
	assign o_rs2_adr = i_inst[24:20];

	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
		i_inst[11:8], 1'b0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
		i_inst[30:21], 1'b0};

	always_comb begin
		o_alu_op      = ALU_ADD;
		o_use_imm     = 1'b0;
		o_cmd_ld      = 1'b0;
		o_cmd_st      = 1'b0;
		o_cmd_br      = 1'b0;
		o_br_ne       = 1'b0;
		o_cmd_jal     = 1'b0;
		o_cmd_ecall   = 1'b0;
		o_illegal_ops = 1'b0;
		o_wbk_rd_reg  = 1'b0;
		o_imm         = imm_i;
		case (opcode)
			OP_ALU: begin
				o_wbk_rd_reg = 1'b1;
				case ({funct7, funct3})
					{F7_BASE, F3_ADD}: o_alu_op = ALU_ADD;
					{F7_SUB,  F3_ADD}: o_alu_op = ALU_SUB;
					{F7_BASE, F3_AND}: o_alu_op = ALU_AND;
					{F7_BASE, F3_OR}:  o_alu_op = ALU_OR;
					{F7_BASE, F3_XOR}: o_alu_op = ALU_XOR;
					{F7_BASE, F3_SLT}: o_alu_op = ALU_SLT;
					default: begin
						o_wbk_rd_reg  = 1'b0;
						o_illegal_ops = 1'b1;
					end
				endcase
			end
			OP_ALUI: begin
				o_use_imm     = 1'b1;  // addi only
				o_wbk_rd_reg  = (funct3 == F3_ADD);
				o_illegal_ops = (funct3 != F3_ADD);
			end
			OP_LOAD: begin
				o_use_imm     = 1'b1;
				o_cmd_ld      = (funct3 == F3_WORD);
				o_wbk_rd_reg  = (funct3 == F3_WORD);
				o_illegal_ops = (funct3 != F3_WORD);
			end
			OP_STORE: begin
				o_use_imm     = 1'b1;
				o_imm         = imm_s;
				o_cmd_st      = (funct3 == F3_WORD);
				o_illegal_ops = (funct3 != F3_WORD);
			end
			OP_BRANCH: begin
				o_imm         = imm_b;
				o_cmd_br      = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
				o_br_ne       = (funct3 == F3_BNE);
				o_illegal_ops = (funct3 != F3_BEQ) && (funct3 != F3_BNE);
			end
			OP_JAL: begin
				o_imm        = imm_j;
				o_cmd_jal    = 1'b1;
				o_wbk_rd_reg = 1'b1;  // link value
			end
			OP_SYSTEM: begin
				o_cmd_ecall   = (i_inst == INST_ECALL);
				o_illegal_ops = (i_inst != INST_ECALL);
			end
			default:   o_illegal_ops = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// register file
// 31 writable registers with x0 reading as zero, both operands are
// latched in idrfr and held through ex
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
	input  wire           clk,
	input  wire           i_rst_n,
	input  wire           i_stat_idrfr,
	input  wire reg_adr_t i_rs1_adr,
	input  wire reg_adr_t i_rs2_adr,
	input  wire           i_wbk_we,
	input  wire reg_adr_t i_wbk_adr,
	input  wire word_t    i_wbk_data,
	output word_t         o_rs1_data,
	output word_t         o_rs2_data
);

	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (i_wbk_we && (i_wbk_adr != '0))
			regs[i_wbk_adr] <= i_wbk_data;  // x0 writes dropped
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
		end else if (i_stat_idrfr) begin
			o_rs1_data <= (i_rs1_adr == '0) ? '0 : regs[i_rs1_adr];
			o_rs2_data <= (i_rs2_adr == '0) ? '0 : regs[i_rs2_adr];
		end
	end

endmodule

`default_nettype wire

// ==== execution.sv ====
// execution stage
// alu and address add, branch compare and pc-relative target; the
// result and store data are registered at the end of ex
`timescale 1ns/1ps
`default_nettype none

module execution import cpu_pkg::*; (
	input  wire          clk,
	input  wire          i_rst_n,
	input  wire          i_stat_ex,
	input  wire word_t   i_pc,
	input  wire word_t   i_rs1_data,
	input  wire word_t   i_rs2_data,
	input  wire word_t   i_imm,
	input  wire alu_op_e i_alu_op,
	input  wire          i_use_imm,
	input  wire          i_cmd_br,
	input  wire          i_br_ne,
	input  wire          i_cmd_jal,
	input  wire          i_cmd_ecall,
	input  wire          i_illegal_ops,
	output word_t        o_result,
	output word_t        o_st_data,
	output logic         o_jmp_cond,
	output word_t        o_jmp_adr,
	output logic         o_halt_req,
	output logic         o_illegal
);

	word_t op_b;
	word_t alu_out;
	logic  br_taken;

	assign op_b = i_use_imm ? i_imm : i_rs2_data;

	always_comb begin
		case (i_alu_op)
			ALU_SUB: alu_out = i_rs1_data - op_b;
			ALU_AND: alu_out = i_rs1_data & op_b;
			ALU_OR:  alu_out = i_rs1_data | op_b;
			ALU_XOR: alu_out = i_rs1_data ^ op_b;
			ALU_SLT: alu_out = {31'd0, $signed(i_rs1_data) < $signed(op_b)};
			default: alu_out = i_rs1_data + op_b;  // add, addi, lw/sw address
		endcase
	end

	assign br_taken   = i_cmd_br & (i_br_ne ^ (i_rs1_data == i_rs2_data));
	assign o_halt_req = i_cmd_ecall | i_illegal_ops;

	// a halting instruction jumps to itself so the pc keeps its address
	assign o_jmp_cond = br_taken | i_cmd_jal | o_halt_req;
	assign o_jmp_adr  = o_halt_req ? i_pc : i_pc + i_imm;

	always_ff @(posedge clk) begin
		if (i_stat_ex) begin
			o_result  <= i_cmd_jal ? i_pc + INST_STEP : alu_out;
			o_st_data <= i_rs2_data;
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_illegal <= 1'b0;
		else if (i_stat_ex)
			o_illegal <= i_illegal_ops;  // held through halt
	end

endmodule

`default_nettype wire

// ==== data_rw_mem.sv ====
// data load/store
// drives the data read or write request through dmrw and returns
// the write-back strobe with load data or the ex result
`timescale 1ns/1ps
`default_nettype none

module data_rw_mem import cpu_pkg::*; (
	input  wire           clk,
	input  wire           i_rst_n,
	input  wire           i_stat_dmrw,
	input  wire           i_cmd_ld,
	input  wire           i_cmd_st,
	input  wire           i_wbk_rd_reg,
	input  wire reg_adr_t i_rd_adr,
	input  wire word_t    i_result,
	input  wire word_t    i_st_data,
	input  wire           i_read_valid,
	input  wire word_t    i_read_data,
	input  wire           i_write_finish,
	output logic          o_d_read_req,
	output word_t         o_d_read_adr,
	output logic          o_d_write_req,
	output word_t         o_d_write_adr,
	output word_t         o_d_write_data,
	output logic          o_dmrw_run,
	output logic          o_wbk_we,
	output reg_adr_t      o_wbk_adr,
	output word_t         o_wbk_data
);

	assign o_d_read_req   = i_stat_dmrw & i_cmd_ld;
	assign o_d_read_adr   = i_result;
	assign o_d_write_req  = i_stat_dmrw & i_cmd_st;
	assign o_d_write_adr  = i_result;
	assign o_d_write_data = i_st_data;

	assign o_dmrw_run = (o_d_read_req & ~i_read_valid) | (o_d_write_req & ~i_write_finish);

	// one pulse on the last dmrw cycle
	assign o_wbk_we   = i_stat_dmrw & i_wbk_rd_reg & ~o_dmrw_run;
	assign o_wbk_adr  = i_rd_adr;
	assign o_wbk_data = i_cmd_ld ? i_read_data : i_result;

	// address and data stay put until the memory answers
	ap_st_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_d_write_req && !i_write_finish) |=>
		(o_d_write_req && $stable(o_d_write_adr) && $stable(o_d_write_data)));

	ap_ld_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_d_read_req && !i_read_valid) |=> (o_d_read_req && $stable(o_d_read_adr)));

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
// cpu top
// multi-cycle RV32I subset core, state machine plus datapath blocks
// on a shared read return and a separate write-finish bus
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  wire        clk,
	input  wire        i_rst_n,
	input  wire        i_cpu_start,
	input  wire        i_quit_cmd,
	input  wire word_t i_cpu_start_adr,
	input  wire        i_read_valid,
	input  wire word_t i_read_data,
	input  wire        i_write_finish,
	output word_t      o_pc_data,
	output logic       o_halted,
	output logic       o_illegal,
	output logic       o_i_read_req,
	output word_t      o_i_read_adr,
	output logic       o_d_read_req,
	output word_t      o_d_read_adr,
	output logic       o_d_write_req,
	output word_t      o_d_write_adr,
	output word_t      o_d_write_data
);

	wire           stat_imr;
	wire           stat_idrfr;
	wire           stat_ex;
	wire           stat_dmrw;
	wire           imr_run;
	wire           dmrw_run;
	wire           halt_req;
	wire word_t    pc;
	wire word_t    inst;
	wire alu_op_e  alu_op;
	wire           use_imm;
	wire           cmd_ld;
	wire           cmd_st;
	wire           cmd_br;
	wire           br_ne;
	wire           cmd_jal;
	wire           cmd_ecall;
	wire           illegal_ops;
	wire           wbk_rd_reg;
	wire reg_adr_t rd_adr;
	wire reg_adr_t rs1_adr;
	wire reg_adr_t rs2_adr;
	wire word_t    imm;
	wire word_t    rs1_data;
	wire word_t    rs2_data;
	wire word_t    result;
	wire word_t    st_data;
	wire           jmp_cond;
	wire word_t    jmp_adr;
	wire           wbk_we;
	wire reg_adr_t wbk_adr;
	wire word_t    wbk_data;

	assign o_pc_data = pc;

	cpu_state_machine cpu_state_machine (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start),
		.i_quit_cmd(i_quit_cmd),
		.i_imr_run(imr_run),
		.i_dmrw_run(dmrw_run),
		.i_halt_req(halt_req),
		.o_stat_pc(),  // pc stage has no work of its own here
		.o_stat_imr(stat_imr),
		.o_stat_idrfr(stat_idrfr),
		.o_stat_ex(stat_ex),
		.o_stat_dmrw(stat_dmrw),
		.o_halted(o_halted)
	);

	pc_stage pc_stage (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start),
		.i_cpu_start_adr(i_cpu_start_adr),
		.i_stat_ex(stat_ex),
		.i_jmp_cond(jmp_cond),
		.i_jmp_adr(jmp_adr),
		.o_pc(pc)
	);

	inst_mem_read inst_mem_read (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_stat_imr(stat_imr),
		.i_pc(pc),
		.i_read_valid(i_read_valid),
		.i_read_data(i_read_data),
		.o_i_read_req(o_i_read_req),
		.o_i_read_adr(o_i_read_adr),
		.o_inst(inst),
		.o_imr_run(imr_run)
	);

	decoder decoder (
		.i_inst(inst),
		.o_alu_op(alu_op),
		.o_use_imm(use_imm),
		.o_cmd_ld(cmd_ld),
		.o_cmd_st(cmd_st),
		.o_cmd_br(cmd_br),
		.o_br_ne(br_ne),
		.o_cmd_jal(cmd_jal),
		.o_cmd_ecall(cmd_ecall),
		.o_illegal_ops(illegal_ops),
		.o_wbk_rd_reg(wbk_rd_reg),
		.o_rd_adr(rd_adr),
		.o_rs1_adr(rs1_adr),
		.o_rs2_adr(rs2_adr),
		.o_imm(imm)
	);

	register_file register_file (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_stat_idrfr(stat_idrfr),
		.i_rs1_adr(rs1_adr),
		.i_rs2_adr(rs2_adr),
		.i_wbk_we(wbk_we),
		.i_wbk_adr(wbk_adr),
		.i_wbk_data(wbk_data),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	execution execution (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_stat_ex(stat_ex),
		.i_pc(pc),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_imm(imm),
		.i_alu_op(alu_op),
		.i_use_imm(use_imm),
		.i_cmd_br(cmd_br),
		.i_br_ne(br_ne),
		.i_cmd_jal(cmd_jal),
		.i_cmd_ecall(cmd_ecall),
		.i_illegal_ops(illegal_ops),
		.o_result(result),
		.o_st_data(st_data),
		.o_jmp_cond(jmp_cond),
		.o_jmp_adr(jmp_adr),
		.o_halt_req(halt_req),
		.o_illegal(o_illegal)
	);

	data_rw_mem data_rw_mem (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_stat_dmrw(stat_dmrw),
		.i_cmd_ld(cmd_ld),
		.i_cmd_st(cmd_st),
		.i_wbk_rd_reg(wbk_rd_reg),
		.i_rd_adr(rd_adr),
		.i_result(result),
		.i_st_data(st_data),
		.i_read_valid(i_read_valid),
		.i_read_data(i_read_data),
		.i_write_finish(i_write_finish),
		.o_d_read_req(o_d_read_req),
		.o_d_read_adr(o_d_read_adr),
		.o_d_write_req(o_d_write_req),
		.o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data),
		.o_dmrw_run(dmrw_run),
		.o_wbk_we(wbk_we),
		.o_wbk_adr(wbk_adr),
		.o_wbk_data(wbk_data)
	);

endmodule

`default_nettype wire

// ==== tb_cpu_top.sv ====
// testbench for cpu_top
// loads short RV32I programs into a behavioral memory that answers
// after a random latency, starts the core at each program and checks
// the last store, the halt address and the illegal flag
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

	localparam int T_CLK = 40;

	logic  clk;
	logic  i_rst_n;
	logic  i_cpu_start;
	logic  i_quit_cmd;
	word_t i_cpu_start_adr;
	logic  i_read_valid;
	word_t i_read_data;
	logic  i_write_finish;
	word_t o_pc_data;
	logic  o_halted;
	logic  o_illegal;
	logic  o_i_read_req;
	word_t o_i_read_adr;
	logic  o_d_read_req;
	word_t o_d_read_adr;
	logic  o_d_write_req;
	word_t o_d_write_adr;
	word_t o_d_write_data;

	word_t mem [0:1023];  // 4 KB, instructions and data
	word_t wp;            // program write pointer
	word_t t_start[$];
	word_t t_st_adr[$];
	word_t t_st_data[$];
	word_t t_halt_pc[$];
	logic  t_illegal[$];
	word_t st_adr;        // last store seen on the bus
	word_t st_data;
	int    st_count;
	int    errors = 0;
	int    cycles = 0;
	int    limit = 1 << 30;

	cpu_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(T_CLK / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: core still running after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_ALU};
	endfunction

	function automatic word_t enc_i(opcode_e op, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_s(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t enc_b(int f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t enc_j(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
	endfunction

	function automatic word_t addi(int rd, int rs1, int imm);
		return enc_i(OP_ALUI, 0, rd, rs1, imm);
	endfunction

	task automatic emit(word_t w);
		mem[wp[11:2]] = w;
		wp = wp + 4;
	endtask

	task automatic add_row(word_t start, word_t adr, word_t data, word_t halt, logic ill);
		t_start.push_back(start);
		t_st_adr.push_back(adr);
		t_st_data.push_back(data);
		t_halt_pc.push_back(halt);
		t_illegal.push_back(ill);
	endtask

	task automatic load_programs();
		word_t start;
		word_t halt;
		word_t link;
		word_t a;
		word_t b;
		word_t sum;
		for (word_t adr = 0; adr < 4096; adr += 4)
			mem[adr[11:2]] = 32'hbad0_0000 | adr;  // unwritten words differ by address

		// register ALU ops, results folded into x10 with a doubling between terms
		wp = 32'h000;
		start = wp;
		emit(addi(1, 0, 1234));
		emit(addi(2, 0, -701));
		emit(enc_r(0, 0, 3, 1, 2));   // add
		emit(enc_r(32, 0, 4, 1, 2));  // sub
		emit(enc_r(0, 7, 5, 1, 2));   // and
		emit(enc_r(0, 6, 6, 1, 2));   // or
		emit(enc_r(0, 4, 7, 1, 2));   // xor
		emit(enc_r(0, 2, 8, 1, 2));   // slt x1 < x2
		emit(enc_r(0, 2, 9, 2, 1));   // slt x2 < x1
		emit(enc_r(0, 0, 10, 3, 0));
		for (int r = 4; r <= 9; r++) begin
			emit(enc_r(0, 0, 10, 10, 10));  // x10 doubled
			emit(enc_r(0, 0, 10, 10, r));
		end
		emit(enc_s(10, 0, 1024));     // sw x10, 0x400(x0)
		halt = wp;
		emit(enc_i(OP_SYSTEM, 0, 0, 0, 0));
		a = 32'd1234;
		b = -32'sd701;
		sum = a + b;
		sum = sum + sum + (a - b);
		sum = sum + sum + (a & b);
		sum = sum + sum + (a | b);
		sum = sum + sum + (a ^ b);
		sum = sum + sum;          // 1234 < -701 is false
		sum = sum + sum + 32'd1;  // -701 < 1234 is true
		add_row(start, 32'h400, sum, halt, 1'b0);

		// negative immediates and a write to x0
		wp = 32'h100;
		start = wp;
		emit(addi(1, 0, -2048));
		emit(addi(2, 1, -1));
		emit(addi(0, 0, 55));         // must be lost
		emit(enc_r(0, 0, 3, 2, 0));   // add x3, x2, x0
		emit(enc_s(3, 0, 1032));
		halt = wp;
		emit(enc_i(OP_SYSTEM, 0, 0, 0, 0));
		add_row(start, 32'h408, -32'sd2049, halt, 1'b0);

		// lui is outside the subset
		wp = 32'h180;
		start = wp;
		emit(addi(1, 0, 99));
		emit(enc_s(1, 0, 1060));
		halt = wp;
		emit({20'h12345, 5'd1, 7'b0110111});
		add_row(start, 32'h424, 32'd99, halt, 1'b1);

		// store of x0, also clears the illegal flag from the run before
		wp = 32'h1c0;
		start = wp;
		emit(addi(0, 0, 77));
		emit(enc_s(0, 0, 1036));
		halt = wp;
		emit(enc_i(OP_SYSTEM, 0, 0, 0, 0));
		add_row(start, 32'h40c, 32'd0, halt, 1'b0);

		// sw then lw, loaded value feeds an add
		wp = 32'h200;
		start = wp;
		emit(addi(5, 0, 1024));
		emit(addi(1, 0, 1443));
		emit(addi(2, 0, -300));
		emit(enc_r(32, 0, 3, 1, 2));
		emit(enc_s(3, 5, 20));
		emit(enc_i(OP_LOAD, 2, 4, 5, 20));
		emit(enc_r(0, 0, 6, 4, 1));
		emit(enc_s(6, 5, 24));
		halt = wp;
		emit(enc_i(OP_SYSTEM, 0, 0, 0, 0));
		add_row(start, 32'h418, (32'd1443 + 32'd300) + 32'd1443, halt, 1'b0);

		// branches and jal, x7 collects markers of the paths that ran
		wp = 32'h300;
		start = wp;
		emit(addi(1, 0, 5));
		emit(addi(2, 0, 5));
		emit(addi(7, 0, 0));
		emit(enc_b(0, 1, 2, 8));      // beq taken
		emit(addi(7, 7, 1));
		emit(addi(7, 7, 2));
		emit(enc_b(1, 1, 2, 8));      // bne not taken
		emit(addi(7, 7, 4));
		emit(addi(2, 0, 6));
		emit(enc_b(1, 1, 2, 8));      // bne taken
		emit(addi(7, 7, 8));
		emit(enc_b(0, 1, 2, 8));      // beq not taken
		emit(addi(7, 7, 16));
		link = wp + 4;
		emit(enc_j(8, 12));           // jal x8 over two words
		emit(addi(7, 7, 32));
		emit(addi(7, 7, 64));
		emit(enc_r(0, 0, 7, 7, 8));
		emit(enc_s(7, 0, 1056));
		halt = wp;
		emit(enc_i(OP_SYSTEM, 0, 0, 0, 0));
		add_row(start, 32'h420, 32'd22 + link, halt, 1'b0);
	endtask

	task automatic check_word(word_t got, word_t exp, string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_pc(word_t got, word_t exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: halt pc is %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// memory model, one request at a time, 0..3 cycles of latency
	initial begin
		int    lat;
		logic  busy;
		word_t seed_rd;
		seed_rd        = $urandom(32'he58f_1b96);
		busy           = 1'b0;
		lat            = 0;
		st_count       = 0;
		st_adr         = '0;
		st_data        = '0;
		i_read_valid   = 1'b0;
		i_read_data    = '0;
		i_write_finish = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			i_read_valid   = 1'b0;
			i_write_finish = 1'b0;
			i_read_data    = '0;
			if (o_i_read_req || o_d_read_req || o_d_write_req) begin
				if (!busy) begin
					busy = 1'b1;
					lat  = $urandom % 4;
				end
				if (lat > 0) begin
					lat = lat - 1;
				end else begin
					busy = 1'b0;
					if (o_d_write_req) begin
						mem[o_d_write_adr[11:2]] = o_d_write_data;
						st_adr         = o_d_write_adr;
						st_data        = o_d_write_data;
						st_count       = st_count + 1;
						i_write_finish = 1'b1;
					end else begin
						i_read_data  = o_i_read_req ? mem[o_i_read_adr[11:2]]
							: mem[o_d_read_adr[11:2]];
						i_read_valid = 1'b1;
					end
				end
			end
		end
	end

	initial begin
		int n_before;
		int err_before;
		int passed;
		passed          = 0;
		i_rst_n         = 1'b0;
		i_cpu_start     = 1'b0;
		i_quit_cmd      = 1'b0;
		i_cpu_start_adr = '0;
		load_programs();
		limit = t_start.size() * 24 * 16;  // rows x instructions x cycles
		repeat (2) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		for (int t = 0; t < t_start.size(); t++) begin
			n_before   = st_count;
			err_before = errors;
			@(posedge clk);
			#1;
			i_cpu_start     = 1'b1;
			i_cpu_start_adr = t_start[t];
			@(posedge clk);
			#1;
			i_cpu_start = 1'b0;
			while (!o_halted) begin
				@(posedge clk);
				#1;
			end
			if (st_count == n_before) begin
				$display("test %0d halted without any store on the bus", t);
				errors++;
			end else begin
				check_word(st_adr, t_st_adr[t], "store address");
				check_word(st_data, t_st_data[t], "store data");
			end
			check_pc(o_pc_data, t_halt_pc[t]);
			check_flag(o_illegal, t_illegal[t], "illegal flag");
			if (errors == err_before) begin
				passed++;
				$display("test %0d from %h: ok", t, t_start[t]);
			end else begin
				$display("test %0d from %h: failed", t, t_start[t]);
			end
		end
		$display("tests %0d, passed %0d, failed %0d, mismatches %0d",
			t_start.size(), passed, t_start.size() - passed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
cpu_pkg.sv
cpu_state_machine.sv
pc_stage.sv
inst_mem_read.sv
decoder.sv
register_file.sv
execution.sv
data_rw_mem.sv
cpu_top.sv
tb_cpu_top.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu_top -f verilog.f
	./obj_dir/Vtb_cpu_top | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
